/* fetchPkg.sv */
package fetchPkg;

    typedef logic [31:0] word_t;    // address or data word
    typedef logic [31:0] inst_t;
    typedef logic [1:0]  bim_t;     // bimodal counter

    // delay-slot handling assumes exactly two slots
    localparam int FetchWidth = 2;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OpSpecial = 6'b000000;
    localparam logic [5:0] OpRegimm  = 6'b000001;
    localparam logic [5:0] OpJ       = 6'b000010;
    localparam logic [5:0] OpJal     = 6'b000011;
    localparam logic [5:0] OpBeq     = 6'b000100;
    localparam logic [5:0] OpBne     = 6'b000101;
    localparam logic [5:0] OpBlez    = 6'b000110;
    localparam logic [5:0] OpBgtz    = 6'b000111;

    // SPECIAL functs, inst[5:0]
    localparam logic [5:0] FunctJr   = 6'b001000;
    localparam logic [5:0] FunctJalr = 6'b001001;

    typedef enum logic {
        waitIdle,
        waitDelaySlot       // slot-1 redirect pending on its delay slot
    } waitState_e;

endpackage

/* fetchIfc.sv */
`timescale 1ns/1ps

interface slotIfc;
    import fetchPkg::*;

    word_t pc;
    inst_t inst;
    logic  valid;
    logic  nlpValid;    // next-line predictor hit
    logic  nlpTaken;
    word_t nlpTarget;
    bim_t  nlpBim;
    logic  bpdValid;    // direction predictor hit
    logic  bpdTaken;

    modport src (
        output pc, inst, valid,
        output nlpValid, nlpTaken, nlpTarget, nlpBim,
        output bpdValid, bpdTaken
    );

    modport dst (
        input pc, inst, valid,
        input nlpValid, nlpTaken, nlpTarget, nlpBim,
        input bpdValid, bpdTaken
    );
endinterface

interface decodeIfc;
    import fetchPkg::*;

    logic  valid;
    word_t pc;
    logic  isJ;
    logic  isBr;
    logic  isJr;
    logic  predTaken;
    word_t predAddr;
    logic  nlpValid;
    logic  nlpTaken;    // already masked by nlpValid
    bim_t  nlpBim;
    logic  bpdValid;    // selects the slot for nlp training

    modport src (
        output valid, pc, isJ, isBr, isJr, predTaken, predAddr,
        output nlpValid, nlpTaken, nlpBim, bpdValid
    );

    modport dst (
        input valid, pc, isJ, isBr, isJr, predTaken, predAddr,
        input nlpValid, nlpTaken, nlpBim, bpdValid
    );
endinterface

/* fetchPacketReg.sv */
`timescale 1ns/1ps

module fetchPacketReg (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          flush,
    input  logic                                          fetchValid,
    input  fetchPkg::word_t                               fetchPc,
    input  fetchPkg::inst_t [fetchPkg::FetchWidth-1:0]    instWord,
    input  logic            [fetchPkg::FetchWidth-1:0]    nlpValid,
    input  logic            [fetchPkg::FetchWidth-1:0]    nlpTaken,
    input  fetchPkg::word_t [fetchPkg::FetchWidth-1:0]    nlpTarget,
    input  fetchPkg::bim_t  [fetchPkg::FetchWidth-1:0]    nlpBim,
    input  logic            [fetchPkg::FetchWidth-1:0]    bpdValid,
    input  logic            [fetchPkg::FetchWidth-1:0]    bpdTaken,
    slotIfc.src                                           slots [fetchPkg::FetchWidth]
);
    import fetchPkg::*;

    for (genvar k = 0; k < FetchWidth; k++) begin : genSlot
        always_ff @(posedge clk) begin
            if (rst || flush) begin
                slots[k].valid    <= 1'b0;
                slots[k].nlpValid <= 1'b0;  // keeps predictor flags known
                slots[k].bpdValid <= 1'b0;
            end else begin
                slots[k].valid <= fetchValid;   // idle cycle leaves both slots invalid
                if (fetchValid) begin
                    slots[k].nlpValid <= nlpValid[k];
                    slots[k].bpdValid <= bpdValid[k];
                end
            end
        end

        // payload, loaded only with a new packet
        always_ff @(posedge clk) begin
            if (fetchValid && !rst && !flush) begin
                slots[k].pc        <= fetchPc + word_t'(4 * k);
                slots[k].inst      <= instWord[k];
                slots[k].nlpTaken  <= nlpTaken[k];
                slots[k].nlpTarget <= nlpTarget[k];
                slots[k].nlpBim    <= nlpBim[k];
                slots[k].bpdTaken  <= bpdTaken[k];
            end
        end
    end

endmodule

/* slotPredecoder.sv */
`timescale 1ns/1ps

module slotPredecoder (
    slotIfc.dst   slot,
    decodeIfc.src dec
);
    import fetchPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      pcPlus4;
    word_t      jTarget;
    word_t      brTarget;
    logic       isJ;
    logic       isBr;
    logic       isJr;
    logic       predTaken;
    word_t      predAddr;

    assign opcode  = slot.inst[31:26];
    assign funct   = slot.inst[5:0];
    assign pcPlus4 = slot.pc + 32'd4;

    // J-format target lives in the 256 MB region of the delay slot
    assign jTarget  = {pcPlus4[31:28], slot.inst[25:0], 2'b00};
    assign brTarget = pcPlus4 + {{14{slot.inst[15]}}, slot.inst[15:0], 2'b00};

    always_comb begin
        isJ  = 1'b0;
        isBr = 1'b0;
        isJr = 1'b0;
        case (opcode)
            OpJ, OpJal: begin
                isJ = 1'b1;
            end
            OpSpecial: begin
                if (funct == FunctJr || funct == FunctJalr) begin
                    isJ  = 1'b1;
                    isJr = 1'b1;    // target only known from the nlp
                end
            end
            OpBeq, OpBne, OpBlez, OpBgtz, OpRegimm: begin
                isBr = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        if (isJr) begin
            predAddr = slot.nlpTarget;
        end else if (isJ) begin
            predAddr = jTarget;
        end else if (isBr) begin
            predAddr = brTarget;
        end else begin
            predAddr = pcPlus4 + 32'd4;     // fall through
        end
    end

    always_comb begin
        if (!slot.valid) begin
            predTaken = 1'b0;
        end else if (isJ && !(isJr && !slot.nlpValid)) begin
            predTaken = 1'b1;               // unconditional
        end else if (!isBr) begin
            predTaken = 1'b0;
        end else if (slot.bpdValid) begin
            predTaken = slot.bpdTaken;
        end else if (slot.nlpValid) begin
            predTaken = slot.nlpTaken;
        end else begin
            predTaken = 1'b0;               // both miss
        end
    end

    assign dec.valid     = slot.valid;
    assign dec.pc        = slot.pc;
    assign dec.isJ       = isJ;
    assign dec.isBr      = isBr;
    assign dec.isJr      = isJr;
    assign dec.predTaken = predTaken;
    assign dec.predAddr  = predAddr;
    assign dec.nlpValid  = slot.nlpValid;
    assign dec.nlpTaken  = slot.nlpValid && slot.nlpTaken;    // drop stale taken bits
    assign dec.nlpBim    = slot.nlpBim;
    assign dec.bpdValid  = slot.bpdValid;

endmodule

/* redirectUnit.sv */
`timescale 1ns/1ps

module redirectUnit #(
    parameter fetchPkg::bim_t BimInit = 2'b01
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          flush,
    decodeIfc.dst                                         dec [fetchPkg::FetchWidth],
    output logic            [fetchPkg::FetchWidth-1:0]    outValid,
    output fetchPkg::word_t [fetchPkg::FetchWidth-1:0]    outPc,
    output logic            [fetchPkg::FetchWidth-1:0]    outIsJ,
    output logic            [fetchPkg::FetchWidth-1:0]    outIsBr,
    output logic            [fetchPkg::FetchWidth-1:0]    outPredTaken,
    output fetchPkg::word_t [fetchPkg::FetchWidth-1:0]    outPredAddr,
    output logic                                          redirect,
    output fetchPkg::word_t                               redirectPc,
    output logic                                          flushReq,
    output logic                                          nlpUpdValid,
    output fetchPkg::word_t                               nlpUpdPc,
    output fetchPkg::word_t                               nlpUpdTarget,
    output fetchPkg::bim_t                                nlpUpdBim,
    output logic                                          nlpUpdTake
);
    import fetchPkg::*;

    logic [FetchWidth-1:0] valid;
    logic [FetchWidth-1:0] isJ;
    logic [FetchWidth-1:0] isBr;
    logic [FetchWidth-1:0] isJr;
    logic [FetchWidth-1:0] predTaken;
    logic [FetchWidth-1:0] nlpValid;
    logic [FetchWidth-1:0] nlpTaken;
    logic [FetchWidth-1:0] bpdValid;
    logic [FetchWidth-1:0] mismatch;
    logic [FetchWidth-1:0] updOk;
    word_t                 pc [FetchWidth];
    word_t                 predAddr [FetchWidth];
    word_t                 fixTarget [FetchWidth];
    bim_t                  nlpBim [FetchWidth];
    waitState_e            state;
    waitState_e            stateNext;
    word_t                 savedTarget;
    logic                  kill;

    for (genvar k = 0; k < FetchWidth; k++) begin : genSlot
        assign valid[k]     = dec[k].valid;
        assign pc[k]        = dec[k].pc;
        assign isJ[k]       = dec[k].isJ;
        assign isBr[k]      = dec[k].isBr;
        assign isJr[k]      = dec[k].isJr;
        assign predTaken[k] = dec[k].predTaken;
        assign predAddr[k]  = dec[k].predAddr;
        assign nlpValid[k]  = dec[k].nlpValid;
        assign nlpTaken[k]  = dec[k].nlpTaken;
        assign nlpBim[k]    = dec[k].nlpBim;
        assign bpdValid[k]  = dec[k].bpdValid;

        // final prediction disagrees with where the nlp steered fetch
        assign mismatch[k]  = valid[k] && (predTaken[k] != nlpTaken[k]);
        assign fixTarget[k] = predTaken[k] ? predAddr[k] : pc[k] + 32'd8;
        assign updOk[k]     = bpdValid[k] || (isJ[k] && !(isJr[k] && !nlpValid[k]));

        assign outPc[k]        = pc[k];
        assign outIsJ[k]       = isJ[k];
        assign outIsBr[k]      = isBr[k];
        assign outPredTaken[k] = predTaken[k];
        assign outPredAddr[k]  = predAddr[k];
    end

    assign kill = rst || flush;

    always_comb begin
        stateNext  = state;
        redirect   = 1'b0;
        redirectPc = '0;
        outValid   = valid;
        if (kill) begin
            stateNext = waitIdle;
            outValid  = '0;
        end else if (state == waitDelaySlot) begin
            outValid[1] = 1'b0;             // beyond the delay slot, wrong path
            if (valid[0]) begin
                redirect   = 1'b1;
                redirectPc = savedTarget;
                stateNext  = waitIdle;
            end
        end else if (mismatch[0]) begin
            redirect   = 1'b1;              // slot 1 is its delay slot, already here
            redirectPc = fixTarget[0];
        end else if (mismatch[1]) begin
            if (isJ[1] || isBr[1]) begin
                stateNext = waitDelaySlot;
            end else begin
                redirect   = 1'b1;          // nlp hit on a non-control inst
                redirectPc = pc[1] + 32'd4;
            end
        end
    end

    assign flushReq = redirect;

    always_ff @(posedge clk) begin
        if (kill) begin
            state <= waitIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (state == waitIdle && stateNext == waitDelaySlot) begin
            savedTarget <= fixTarget[1];
        end
    end

    // one training update, lowest valid slot wins
    always_comb begin
        nlpUpdValid  = 1'b0;
        nlpUpdPc     = '0;
        nlpUpdTarget = '0;
        nlpUpdBim    = '0;
        nlpUpdTake   = 1'b0;
        for (int k = FetchWidth - 1; k >= 0; k--) begin
            if (outValid[k] && updOk[k]) begin
                nlpUpdValid  = 1'b1;
                nlpUpdPc     = pc[k];
                nlpUpdTarget = predAddr[k];
                nlpUpdBim    = nlpValid[k] ? nlpBim[k] : BimInit;
                nlpUpdTake   = predTaken[k];
            end
        end
    end

endmodule

/* fetchStage3.sv */
`timescale 1ns/1ps

module fetchStage3 #(
    parameter fetchPkg::bim_t BimInit = 2'b01
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          flush,
    input  logic                                          fetchValid,
    input  fetchPkg::word_t                               fetchPc,
    input  fetchPkg::inst_t [fetchPkg::FetchWidth-1:0]    instWord,
    input  logic            [fetchPkg::FetchWidth-1:0]    nlpValid,
    input  logic            [fetchPkg::FetchWidth-1:0]    nlpTaken,
    input  fetchPkg::word_t [fetchPkg::FetchWidth-1:0]    nlpTarget,
    input  fetchPkg::bim_t  [fetchPkg::FetchWidth-1:0]    nlpBim,
    input  logic            [fetchPkg::FetchWidth-1:0]    bpdValid,
    input  logic            [fetchPkg::FetchWidth-1:0]    bpdTaken,
    output logic            [fetchPkg::FetchWidth-1:0]    outValid,
    output fetchPkg::word_t [fetchPkg::FetchWidth-1:0]    outPc,
    output logic            [fetchPkg::FetchWidth-1:0]    outIsJ,
    output logic            [fetchPkg::FetchWidth-1:0]    outIsBr,
    output logic            [fetchPkg::FetchWidth-1:0]    outPredTaken,
    output fetchPkg::word_t [fetchPkg::FetchWidth-1:0]    outPredAddr,
    output logic                                          redirect,
    output fetchPkg::word_t                               redirectPc,
    output logic                                          flushReq,
    output logic                                          nlpUpdValid,
    output fetchPkg::word_t                               nlpUpdPc,
    output fetchPkg::word_t                               nlpUpdTarget,
    output fetchPkg::bim_t                                nlpUpdBim,
    output logic                                          nlpUpdTake
);
    import fetchPkg::*;

    slotIfc   slots [FetchWidth] ();
    decodeIfc decs  [FetchWidth] ();

    fetchPacketReg uPacketReg (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .instWord   (instWord),
        .nlpValid   (nlpValid),
        .nlpTaken   (nlpTaken),
        .nlpTarget  (nlpTarget),
        .nlpBim     (nlpBim),
        .bpdValid   (bpdValid),
        .bpdTaken   (bpdTaken),
        .slots      (slots)
    );

    for (genvar k = 0; k < FetchWidth; k++) begin : genPredecode
        slotPredecoder uPredecoder (
            .slot (slots[k]),
            .dec  (decs[k])
        );
    end

    redirectUnit #(
        .BimInit (BimInit)
    ) uRedirect (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .dec          (decs),
        .outValid     (outValid),
        .outPc        (outPc),
        .outIsJ       (outIsJ),
        .outIsBr      (outIsBr),
        .outPredTaken (outPredTaken),
        .outPredAddr  (outPredAddr),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .flushReq     (flushReq),
        .nlpUpdValid  (nlpUpdValid),
        .nlpUpdPc     (nlpUpdPc),
        .nlpUpdTarget (nlpUpdTarget),
        .nlpUpdBim    (nlpUpdBim),
        .nlpUpdTake   (nlpUpdTake)
    );

endmodule

/* tbFetchStage3.sv */
`timescale 1ns/1ps

module tbFetchStage3;
    import fetchPkg::*;

    typedef struct packed {
        logic       fv;
        logic       fl;
        word_t      pc;
        inst_t      i0;
        inst_t      i1;
        logic [1:0] nv;
        logic [1:0] nt;
        word_t      tg;         // nlp target, same for both slots
        logic [1:0] bv;
        logic [1:0] bt;
        logic       eRed;
        word_t      eRedPc;
        logic       eV1;
        logic       eUpd;
        word_t      eUpdTgt;
    } row_t;

    localparam bim_t         TbBimInit = 2'b10;
    localparam bim_t   [1:0] SlotBim   = {2'b00, 2'b11};   // nlp counters for slot 1 then slot 0
    localparam inst_t        InstNop   = 32'h0000_0000;
    localparam inst_t        InstJ     = 32'h0800_0400;    // index 0x400
    localparam inst_t        InstJal   = 32'h0C00_0800;
    localparam inst_t        InstBeq   = 32'h1000_0010;    // offset +0x40
    localparam inst_t        InstBne   = 32'h1420_FFF0;    // offset -0x40
    localparam inst_t        InstJr    = 32'h03E0_0008;    // jr $ra

    logic                         clk;
    logic                         rst;
    logic                         flush;
    logic                         fetchValid;
    word_t                        fetchPc;
    inst_t [FetchWidth-1:0]       instWord;
    logic  [FetchWidth-1:0]       nlpValid;
    logic  [FetchWidth-1:0]       nlpTaken;
    word_t [FetchWidth-1:0]       nlpTarget;
    bim_t  [FetchWidth-1:0]       nlpBim;
    logic  [FetchWidth-1:0]       bpdValid;
    logic  [FetchWidth-1:0]       bpdTaken;
    logic  [FetchWidth-1:0]       outValid;
    word_t [FetchWidth-1:0]       outPc;
    logic  [FetchWidth-1:0]       outIsJ;
    logic  [FetchWidth-1:0]       outIsBr;
    logic  [FetchWidth-1:0]       outPredTaken;
    word_t [FetchWidth-1:0]       outPredAddr;
    logic                         redirect;
    word_t                        redirectPc;
    logic                         flushReq;
    logic                         nlpUpdValid;
    word_t                        nlpUpdPc;
    word_t                        nlpUpdTarget;
    bim_t                         nlpUpdBim;
    logic                         nlpUpdTake;
    int                           errors;
    int                           checks;
    logic [31:0]                  seed;
    row_t                         rows [$];

    fetchStage3 #(.BimInit(TbBimInit)) u_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // {isJ, isBr, isJr}
    function automatic logic [2:0] kindOf(input inst_t i);
        case (i[31:26])
            OpJ, OpJal: return 3'b100;
            OpBeq, OpBne, OpBlez, OpBgtz, OpRegimm: return 3'b010;
            OpSpecial: return (i[5:0] == FunctJr || i[5:0] == FunctJalr) ? 3'b101 : 3'b000;
            default: return 3'b000;
        endcase
    endfunction

    function automatic word_t targetOf(input inst_t i, input word_t pc, input word_t nlpTgt);
        logic [2:0] kd;
        word_t      next;
        kd = kindOf(i);
        next = pc + 32'd4;
        if (kd[0]) return nlpTgt;
        if (kd[2]) return {next[31:28], i[25:0], 2'b00};
        return next + {{14{i[15]}}, i[15:0], 2'b00};
    endfunction

    // prediction of a valid slot
    function automatic logic takenOf(input inst_t i, input logic nv, input logic nt,
                                     input logic bv, input logic bt);
        logic [2:0] kd;
        kd = kindOf(i);
        if (kd[2] && !(kd[0] && !nv)) return 1'b1;
        if (!kd[1]) return 1'b0;
        if (bv) return bt;
        if (nv) return nt;
        return 1'b0;
    endfunction

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %b got %b", $time, name, expVal, actVal);
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] expVal,
                             input logic [31:0] actVal);
        checks++;
        if (actVal !== expVal) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, expVal, actVal);
        end
    endtask

    task automatic driveRow(input row_t r);
        fetchValid = r.fv;
        flush      = r.fl;
        fetchPc    = r.pc;
        instWord   = {r.i1, r.i0};
        nlpValid   = r.nv;
        nlpTaken   = r.nt;
        nlpTarget  = {r.tg, r.tg};
        bpdValid   = r.bv;
        bpdTaken   = r.bt;
    endtask

    task automatic checkRow(input row_t r);
        logic [2:0] kd;
        inst_t      si;
        word_t      spc;
        int         s;
        checkBit("redirect", r.eRed, redirect);
        checkBit("flushReq", r.eRed, flushReq);
        checkWord("redirectPc", r.eRedPc, redirectPc);
        checkBit("outValid[0]", r.fv && !r.fl, outValid[0]);
        checkBit("outValid[1]", r.eV1, outValid[1]);
        checkBit("nlpUpdValid", r.eUpd, nlpUpdValid);
        if (r.eUpd) begin
            kd = kindOf(r.i0);
            s = (r.bv[0] || (kd[2] && !(kd[0] && !r.nv[0]))) ? 0 : 1;    // slot 0 first
            si = (s == 0) ? r.i0 : r.i1;
            checkWord("nlpUpdTarget", r.eUpdTgt, nlpUpdTarget);
            checkWord("nlpUpdPc", r.pc + 32'(4 * s), nlpUpdPc);
            checkWord("nlpUpdBim", {30'b0, (r.nv[s] ? SlotBim[s] : TbBimInit)},
                      {30'b0, nlpUpdBim});
            checkBit("nlpUpdTake", takenOf(si, r.nv[s], r.nt[s], r.bv[s], r.bt[s]), nlpUpdTake);
        end
        if (r.fv && !r.fl) begin
            for (int k = 0; k < FetchWidth; k++) begin
                si = (k == 0) ? r.i0 : r.i1;
                spc = r.pc + 32'(4 * k);
                kd = kindOf(si);
                checkWord($sformatf("outPc[%0d]", k), spc, outPc[k]);
                checkBit($sformatf("outIsJ[%0d]", k), kd[2], outIsJ[k]);
                checkBit($sformatf("outIsBr[%0d]", k), kd[1], outIsBr[k]);
                checkBit($sformatf("outPredTaken[%0d]", k),
                         takenOf(si, r.nv[k], r.nt[k], r.bv[k], r.bt[k]), outPredTaken[k]);
                if (kd != 3'b000) begin
                    checkWord($sformatf("outPredAddr[%0d]", k), targetOf(si, spc, r.tg),
                              outPredAddr[k]);
                end
            end
        end
    endtask

    // each row is fetchValid flush pc inst0 inst1 nlpValid nlpTaken nlpTarget bpdValid
    // bpdTaken and the expected redirect redirectPc outValid[1] nlpUpdValid nlpUpdTarget
    task automatic loadTable();
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0100, InstJ, InstNop, 2'b01, 2'b01,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b1, 1'b1, 32'h1000_1000});  // nlp agrees
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0200, InstJal, InstNop, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b1, 32'h1000_2000, 1'b1, 1'b1, 32'h1000_2000});
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0300, InstBeq, InstNop, 2'b01, 2'b00,
            32'h0, 2'b01, 2'b01, 1'b1, 32'h1000_0344, 1'b1, 1'b1, 32'h1000_0344});  // bpd wins
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0400, InstBne, InstNop, 2'b01, 2'b01,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0});  // nlp only
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0500, InstBeq, InstJr, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0});  // both miss and jr w/o hit
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0600, InstBeq, InstJr, 2'b10, 2'b10,
            32'h2000_0040, 2'b01, 2'b00, 1'b0, 32'h0, 1'b1, 1'b1, 32'h1000_0644});
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0700, InstNop, InstNop, 2'b01, 2'b01,
            32'h0, 2'b00, 2'b00, 1'b1, 32'h1000_0708, 1'b1, 1'b0, 32'h0});  // wrongly taken
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0800, InstNop, InstBne, 2'b00, 2'b00,
            32'h0, 2'b10, 2'b10, 1'b0, 32'h0, 1'b1, 1'b1, 32'h1000_07C8});  // slot 1 waits
        rows.push_back(row_t'{1'b0, 1'b0, 32'h0, InstNop, InstNop, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0});
        rows.push_back(row_t'{1'b0, 1'b0, 32'h0, InstNop, InstNop, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0});
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0808, InstNop, InstNop, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b1, 32'h1000_07C8, 1'b0, 1'b0, 32'h0});  // delay slot
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_07C8, InstNop, InstNop, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0});
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_0900, InstNop, InstJ, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b1, 1'b1, 32'h1000_1000});
        rows.push_back(row_t'{1'b0, 1'b0, 32'h0, InstNop, InstNop, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0});  // now in the wait state
        rows.push_back(row_t'{1'b0, 1'b1, 32'h0, InstNop, InstNop, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0});  // flush drops the wait
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_1000, InstNop, InstNop, 2'b00, 2'b00,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b1, 1'b0, 32'h0});
        rows.push_back(row_t'{1'b1, 1'b0, 32'h1000_1100, InstNop, InstNop, 2'b10, 2'b10,
            32'h0, 2'b00, 2'b00, 1'b1, 32'h1000_1108, 1'b1, 1'b0, 32'h0});
    endtask

    // an nlp taken hit on a non-control packet sends fetch to pc+8
    task automatic addRandomRows(input int count);
        word_t      pc;
        inst_t      i0;
        inst_t      i1;
        logic [1:0] nv;
        logic [1:0] nt;
        logic       red;
        for (int n = 0; n < count; n++) begin
            seed = xorshift(seed);
            pc = {seed[31:2], 2'b00};
            seed = xorshift(seed);
            i0 = {6'(8 + seed[31:26] % 56), seed[25:0]};   // opcode above the branch range
            seed = xorshift(seed);
            i1 = {6'(8 + seed[31:26] % 56), seed[25:0]};
            nv = seed[1:0];
            nt = seed[3:2];
            red = |(nv & nt);
            rows.push_back(row_t'{1'b1, 1'b0, pc, i0, i1, nv, nt, 32'h0, 2'b00, seed[5:4],
                red, (red ? pc + 32'd8 : 32'h0), 1'b1, 1'b0, 32'h0});
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        errors = 0;
        checks = 0;
        seed = 32'h227e_d54a;
        driveRow(row_t'{1'b1, 1'b0, 32'h1000_0000, InstNop, InstNop, 2'b11, 2'b11,
            32'h0, 2'b00, 2'b00, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0});  // would redirect
        nlpBim = SlotBim;
        loadTable();
        addRandomRows(40);
        repeat (5) begin
            @(negedge clk);
            checkBit("redirect", 1'b0, redirect);
            checkBit("flushReq", 1'b0, flushReq);
            checkWord("redirectPc", 32'h0, redirectPc);
            checkBit("nlpUpdValid", 1'b0, nlpUpdValid);
            checkWord("outValid", 32'h0, {30'b0, outValid});
        end
        rst = 1'b0;
        foreach (rows[n]) begin
            driveRow(rows[n]);
            @(negedge clk);
            checkRow(rows[n]);
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
fetchPkg.sv
fetchIfc.sv
fetchPacketReg.sv
slotPredecoder.sv
redirectUnit.sv
fetchStage3.sv
tbFetchStage3.sv
